// ==== source/sata_fifo_pkg.sv ====
package sata_fifo_pkg;

    // payload of one transfer unit
    typedef logic [31:0] dword_t;   // one SATA dword
    typedef logic [1:0]  mask_t;    // word-valid bits, one per 16-bit half

    // host -> device entry tags
    typedef enum logic [1:0] {
        FIS_DATA = 2'd0,            // body dword
        FIS_HEAD = 2'd1,            // first dword of a FIS
        FIS_LAST = 2'd2             // closing dword, link sends EOF after it
    } h2d_type_e;

    // device -> host entry tags
    typedef enum logic [1:0] {
        DMA  = 2'd0,                // body dword of incoming FIS
        HEAD = 2'd1,                // first dword of incoming FIS
        OK   = 2'd2,                // status entry, FIS received clean
        ERR  = 2'd3                 // status entry, FIS invalidated by link
    } d2h_type_e;

    // fifo words, tag on top as the host sees it
    typedef struct packed {
        h2d_type_e fis_type;        // 2 bits
        mask_t     mask;            // 2 bits
        dword_t    data;            // 32 bits
    } h2d_entry_t;                  // 36 bits

    typedef struct packed {
        d2h_type_e fis_type;        // 2 bits
        mask_t     mask;            // 2 bits
        dword_t    data;            // 32 bits
    } d2h_entry_t;                  // 36 bits

    // fill thresholds, in entries
    localparam int unsigned HOST_RESERVE     = 8;   // free slots kept when host is stopped
    localparam int unsigned LINK_BUSY_MARGIN = 64;  // room left for link in flight data
    localparam int unsigned D2H_MANY_LEVEL   = 8;   // host may burst-read from here

endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  ADDR_WIDTH = 9,              // log2 of depth
    parameter type entry_t    = logic [35:0]    // stored payload
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,          // drop contents, same as rst
    input  logic                wr,             // push wr_entry
    input  entry_t              wr_entry,
    input  logic                rd,             // pop head entry
    output entry_t              rd_entry,       // head entry, valid with nonempty
    output logic                nonempty,
    output logic [ADDR_WIDTH:0] fill            // entries held
);

    localparam int unsigned         DEPTH     = 2 ** ADDR_WIDTH;
    localparam logic [ADDR_WIDTH:0] FULL_FILL = {1'b1, {ADDR_WIDTH{1'b0}}};

    entry_t                mem [DEPTH];         // storage, no reset
    logic [ADDR_WIDTH-1:0] wr_ptr;              // next slot to write
    logic [ADDR_WIDTH-1:0] rd_ptr;              // slot of the head entry
    logic [ADDR_WIDTH-1:0] next_rd_ptr;         // head slot for next cycle
    logic                  clear;

    assign clear       = rst || flush;
    assign next_rd_ptr = rd_ptr + {{(ADDR_WIDTH - 1){1'b0}}, rd};
    assign nonempty    = (fill != '0);          // fill is registered, so one cycle after wr

    // pointers
    always_ff @(posedge clk) begin
        if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // fill count, simultaneous wr and rd leaves it unchanged
    always_ff @(posedge clk) begin
        if (clear) begin
            fill <= '0;
        end else begin
            case ({wr, rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // memory write port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // output register holds the entry at next_rd_ptr
    // a write into that very slot is forwarded so the head
    // shows up one cycle after it was pushed into an empty fifo
    always_ff @(posedge clk) begin
        if (wr && (wr_ptr == next_rd_ptr)) begin
            rd_entry <= wr_entry;               // bypass
        end else begin
            rd_entry <= mem[next_rd_ptr];       // registered read
        end
    end

    // overflow, the link busy and host ready margins must prevent it
    a_no_write_full: assert property (
        @(posedge clk) disable iff (clear)
        wr |-> (fill != FULL_FILL)
    ) else $error("sync_fifo: write while full");

    // underflow, consumers gate rd with nonempty
    a_no_read_empty: assert property (
        @(posedge clk) disable iff (clear)
        rd |-> nonempty
    ) else $error("sync_fifo: read while empty");

endmodule

// ==== source/h2d_xmit_buffer.sv ====
`timescale 1ns/1ps

module h2d_xmit_buffer
    import sata_fifo_pkg::*;
#(
    parameter int ADDR_WIDTH      = 9,  // log2 of fifo depth
    parameter int XMIT_START_BITS = 5   // start sending at 2**this entries
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,            // PxCMD.ST cleared, empties fifo
    // host side
    input  dword_t    h2d_data,
    input  mask_t     h2d_mask,
    input  h2d_type_e h2d_type,
    input  logic      h2d_valid,
    output logic      h2d_ready,
    // link side
    output dword_t    ll_h2d_data,
    output mask_t     ll_h2d_mask,
    output logic      ll_h2d_last,      // head entry closes the FIS
    output logic      ll_h2d_valid,
    input  logic      ll_strobe,        // link takes head entry
    output logic      ll_frame_req,     // ask link to open a frame
    input  logic      ll_frame_ack
);

    localparam int unsigned READY_LIMIT = (2 ** ADDR_WIDTH) - HOST_RESERVE;

    logic                accept;        // host dword goes in this cycle
    logic                pop;
    logic                pending;       // HEAD seen, request not raised yet
    logic                start_xmit;
    h2d_entry_t          wr_entry;
    h2d_entry_t          head;
    logic [ADDR_WIDTH:0] fill;

    assign accept   = h2d_valid && h2d_ready;
    assign pop      = ll_h2d_valid && ll_strobe;
    assign wr_entry = '{fis_type: h2d_type, mask: h2d_mask, data: h2d_data};

    sync_fifo #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .entry_t    (h2d_entry_t)
    ) i_fifo (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .wr       (accept),
        .wr_entry (wr_entry),
        .rd       (pop),
        .rd_entry (head),
        .nonempty (ll_h2d_valid),
        .fill     (fill)
    );

    assign ll_h2d_data = head.data;
    assign ll_h2d_mask = head.mask;
    assign ll_h2d_last = (head.fis_type == FIS_LAST);
    assign h2d_ready   = (fill < READY_LIMIT[ADDR_WIDTH:0]);   // keep HOST_RESERVE slots

    // whole FIS is in, or enough of it to keep the link fed
    assign start_xmit = pending &&
                        ((accept && (h2d_type == FIS_LAST)) ||
                         (|fill[ADDR_WIDTH:XMIT_START_BITS]));

    always_ff @(posedge clk) begin
        if (rst || ll_frame_req) begin
            pending <= 1'b0;            // one request per FIS
        end else if (accept && (h2d_type == FIS_HEAD)) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ll_frame_req <= 1'b0;
        end else if (start_xmit) begin
            ll_frame_req <= 1'b1;
        end else if (ll_frame_ack) begin
            ll_frame_req <= 1'b0;       // link took the frame
        end
    end

    // request is a level held until the link answers
    a_req_until_ack: assert property (
        @(posedge clk) disable iff (rst)
        (ll_frame_req && !ll_frame_ack) |=> ll_frame_req
    ) else $error("h2d_xmit_buffer: frame request dropped before ack");

endmodule

// ==== source/d2h_recv_buffer.sv ====
`timescale 1ns/1ps

module d2h_recv_buffer
    import sata_fifo_pkg::*;
#(
    parameter int ADDR_WIDTH = 9        // log2 of fifo depth
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,            // PxCMD.ST cleared, empties fifo
    // link side
    input  dword_t    ll_d2h_data,
    input  mask_t     ll_d2h_mask,
    input  logic      ll_d2h_valid,     // one dword per cycle, no back-pressure
    input  logic      ll_incom_start,   // pulse, FIS begins
    input  logic      ll_incom_done,    // pulse, FIS ended clean
    input  logic      ll_incom_invalidate, // pulse, FIS ended bad
    output logic      ll_d2h_busy,      // link should stop sending
    // host side
    output dword_t    d2h_data,
    output mask_t     d2h_mask,
    output d2h_type_e d2h_type,
    output logic      d2h_valid,
    input  logic      d2h_ready,
    output logic      d2h_many          // enough entries for a burst
);

    localparam int unsigned BUSY_LEVEL = (2 ** ADDR_WIDTH) - LINK_BUSY_MARGIN;

    d2h_type_e           tag;           // tag for the next pushed entry
    logic                invalidate_d;  // lets the last data dword pass first
    logic                fis_end;
    logic                fis_over;      // push status entry this cycle
    logic                push;
    logic                pop;
    d2h_entry_t          wr_entry;
    d2h_entry_t          head;
    logic [ADDR_WIDTH:0] fill;

    assign fis_end  = ll_incom_done || invalidate_d;
    assign push     = ll_d2h_valid || fis_over;
    assign pop      = d2h_valid && d2h_ready;
    assign wr_entry = '{fis_type: tag, mask: ll_d2h_mask, data: ll_d2h_data}; // status data is don't care

    always_ff @(posedge clk) begin
        if (rst) begin
            invalidate_d <= 1'b0;
        end else begin
            invalidate_d <= ll_incom_invalidate;
        end
    end

    // HEAD until first dword, then DMA, then OK/ERR at the end
    always_ff @(posedge clk) begin
        if (rst || ll_incom_start) begin
            tag <= HEAD;
        end else if (ll_d2h_valid) begin
            tag <= DMA;
        end else if (fis_end) begin
            tag <= invalidate_d ? ERR : OK;
        end
    end

    // only once per FIS, and only after some data went in
    always_ff @(posedge clk) begin
        if (rst) begin
            fis_over <= 1'b0;
        end else begin
            fis_over <= fis_end && (tag == DMA);
        end
    end

    sync_fifo #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .entry_t    (d2h_entry_t)
    ) i_fifo (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .wr       (push),
        .wr_entry (wr_entry),
        .rd       (pop),
        .rd_entry (head),
        .nonempty (d2h_valid),
        .fill     (fill)
    );

    assign d2h_data    = head.data;
    assign d2h_mask    = head.mask;
    assign d2h_type    = head.fis_type;
    assign ll_d2h_busy = (fill >= BUSY_LEVEL[ADDR_WIDTH:0]);
    assign d2h_many    = (fill >= D2H_MANY_LEVEL[ADDR_WIDTH:0]);

    // status push shares the write port with link data
    a_status_no_data: assert property (
        @(posedge clk) disable iff (rst)
        fis_over |-> !ll_d2h_valid
    ) else $error("d2h_recv_buffer: link data during status push");

endmodule

// ==== source/sata_transport_top.sv ====
`timescale 1ns/1ps

module sata_transport_top
    import sata_fifo_pkg::*;
#(
    parameter int ADDR_WIDTH      = 9,  // fifo depth 2**ADDR_WIDTH, both directions
    parameter int XMIT_START_BITS = 5   // early frame start threshold
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      pcmd_st_cleared,  // PxCMD.ST 1->0, flushes both fifos
    // host -> device, host side
    input  dword_t    h2d_data,
    input  mask_t     h2d_mask,
    input  h2d_type_e h2d_type,
    input  logic      h2d_valid,
    output logic      h2d_ready,
    // host -> device, link side
    output dword_t    ll_h2d_data,
    output mask_t     ll_h2d_mask,
    output logic      ll_h2d_last,
    output logic      ll_h2d_valid,
    input  logic      ll_strobe,
    output logic      ll_frame_req,
    input  logic      ll_frame_ack,
    // device -> host, link side
    input  dword_t    ll_d2h_data,
    input  mask_t     ll_d2h_mask,
    input  logic      ll_d2h_valid,
    input  logic      ll_incom_start,
    input  logic      ll_incom_done,
    input  logic      ll_incom_invalidate,
    output logic      ll_d2h_busy,
    // device -> host, host side
    output dword_t    d2h_data,
    output mask_t     d2h_mask,
    output d2h_type_e d2h_type,
    output logic      d2h_valid,
    input  logic      d2h_ready,
    output logic      d2h_many
);

    h2d_xmit_buffer #(
        .ADDR_WIDTH      (ADDR_WIDTH),
        .XMIT_START_BITS (XMIT_START_BITS)
    ) i_h2d (
        .clk          (clk),
        .rst          (rst),
        .flush        (pcmd_st_cleared),
        .h2d_data     (h2d_data),
        .h2d_mask     (h2d_mask),
        .h2d_type     (h2d_type),
        .h2d_valid    (h2d_valid),
        .h2d_ready    (h2d_ready),
        .ll_h2d_data  (ll_h2d_data),
        .ll_h2d_mask  (ll_h2d_mask),
        .ll_h2d_last  (ll_h2d_last),
        .ll_h2d_valid (ll_h2d_valid),
        .ll_strobe    (ll_strobe),
        .ll_frame_req (ll_frame_req),
        .ll_frame_ack (ll_frame_ack)
    );

    d2h_recv_buffer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_d2h (
        .clk                 (clk),
        .rst                 (rst),
        .flush               (pcmd_st_cleared),
        .ll_d2h_data         (ll_d2h_data),
        .ll_d2h_mask         (ll_d2h_mask),
        .ll_d2h_valid        (ll_d2h_valid),
        .ll_incom_start      (ll_incom_start),
        .ll_incom_done       (ll_incom_done),
        .ll_incom_invalidate (ll_incom_invalidate),
        .ll_d2h_busy         (ll_d2h_busy),
        .d2h_data            (d2h_data),
        .d2h_mask            (d2h_mask),
        .d2h_type            (d2h_type),
        .d2h_valid           (d2h_valid),
        .d2h_ready           (d2h_ready),
        .d2h_many            (d2h_many)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,     // clock period
    parameter int RESET_CYCLES = 16     // cycles with rst high
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                    // released on an edge like the stimulus
    end

endmodule

// ==== verification/tb_sata_transport.sv ====
`timescale 1ns/1ps

module tb_sata_transport
    import sata_fifo_pkg::*;
;
    localparam int unsigned DEPTH = 512;               // 2**ADDR_WIDTH at default

    logic clk, rst, pcmd_st_cleared;
    dword_t h2d_data, ll_h2d_data, ll_d2h_data, d2h_data;
    mask_t h2d_mask, ll_h2d_mask, ll_d2h_mask, d2h_mask;
    h2d_type_e h2d_type;
    d2h_type_e d2h_type;
    logic h2d_valid, h2d_ready, ll_h2d_last, ll_h2d_valid, ll_strobe, ll_frame_req;
    logic ll_frame_ack, ll_d2h_valid, ll_incom_start, ll_incom_done, ll_incom_invalidate;
    logic ll_d2h_busy, d2h_valid, d2h_ready, d2h_many;

    h2d_entry_t h2d_q[$];                                // expected fifo contents
    d2h_entry_t d2h_q[$];
    int unsigned rng = 68;
    int unsigned errors = 0, checks = 0, tests = 0, test_err = 0;
    int unsigned cycles = 0, limit = 2000;
    string cur_test = "reset";
    logic m_pending = 0, m_req = 0;                      // frame request model
    int unsigned strobe_pct = 0, ready_pct = 0, ack_cnt = 0, lasts_taken = 0;
    logic ack_en = 1;
    int unsigned h2d_fis_left = 0, h2d_left = 0, len_min = 2, len_max = 31;
    logic h2d_first = 0;
    int unsigned d2h_fis_left = 0, d2h_left = 0, d2h_phase = 0, d2h_gap = 0, stat_wait = 0;
    logic d2h_bad = 0, d2h_first = 0, stat_err = 0;

    tb_clock_gen i_clk (.clk(clk), .rst(rst));

    sata_transport_top i_dut (.*);

    function automatic int unsigned xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic compare_bit(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %0b actual %0b", cur_test, name, exp, act);
        end
    endtask

    task automatic compare_h2d(string name, h2d_entry_t exp, h2d_entry_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", cur_test, name, exp, act);
        end
    endtask

    task automatic compare_d2h(string name, d2h_entry_t exp, d2h_entry_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", cur_test, name, exp, act);
        end
    endtask

    // hard stop sized from the dwords each test announces
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run exceeded %0d cycles in test %s", limit, cur_test);
            $display("Finished with errors");
            $finish;
        end
    end

    // per clock sample what the DUT saw at this edge, update models and drive next inputs
    task automatic step();
        logic acc, pop_h, pop_d, start;
        h2d_entry_t exp_h, act_h, new_h;
        d2h_entry_t exp_d, act_d, new_d;
        @(posedge clk);
        acc   = h2d_valid && h2d_ready;
        pop_h = ll_strobe && ll_h2d_valid;
        pop_d = d2h_ready && d2h_valid;
        if (rst) begin
            h2d_q.delete();
            d2h_q.delete();
            m_pending = 0;
            m_req = 0;
        end else begin
            compare_bit("h2d_ready", h2d_q.size() < DEPTH - 8, h2d_ready);
            compare_bit("ll_h2d_valid", h2d_q.size() != 0, ll_h2d_valid);
            compare_bit("ll_frame_req", m_req, ll_frame_req);
            compare_bit("ll_d2h_busy", d2h_q.size() >= DEPTH - 64, ll_d2h_busy);
            compare_bit("d2h_many", d2h_q.size() >= 8, d2h_many);
            compare_bit("d2h_valid", d2h_q.size() != 0, d2h_valid);
            // frame request rules
            start = m_pending && ((acc && h2d_type == FIS_LAST) || h2d_q.size() >= 32);
            if (m_req) m_pending = 0;
            else if (acc && h2d_type == FIS_HEAD) m_pending = 1;
            if (start) m_req = 1;
            else if (ll_frame_ack) m_req = 0;
            if (pop_h && h2d_q.size() != 0) begin
                exp_h = h2d_q.pop_front();
                if (exp_h.fis_type != FIS_LAST) exp_h.fis_type = FIS_DATA;   // link sees last only
                act_h = '{fis_type: ll_h2d_last ? FIS_LAST : FIS_DATA,
                          mask: ll_h2d_mask, data: ll_h2d_data};
                compare_h2d("h2d entry", exp_h, act_h);
            end
            if (pop_d && d2h_q.size() != 0) begin
                exp_d = d2h_q.pop_front();
                act_d = '{fis_type: d2h_type, mask: d2h_mask, data: d2h_data};
                if (exp_d.fis_type == OK || exp_d.fis_type == ERR) begin
                    act_d.mask = '0;                     // status payload undefined
                    act_d.data = '0;
                end
                compare_d2h("d2h entry", exp_d, act_d);
            end
            if (acc && h2d_type == FIS_LAST) lasts_taken++;
            if (pcmd_st_cleared) begin
                h2d_q.delete();
                d2h_q.delete();
                stat_wait = 0;
            end else begin
                if (acc) begin
                    new_h = '{fis_type: h2d_type, mask: h2d_mask, data: h2d_data};
                    h2d_q.push_back(new_h);
                end
                if (stat_wait != 0) begin
                    stat_wait--;
                    if (stat_wait == 0) begin
                        new_d = '{fis_type: OK, mask: '0, data: '0};
                        if (stat_err) new_d.fis_type = ERR;
                        d2h_q.push_back(new_d);
                    end
                end
                if (ll_d2h_valid) begin
                    new_d = '{fis_type: DMA, mask: ll_d2h_mask, data: ll_d2h_data};
                    if (d2h_first) new_d.fis_type = HEAD;
                    d2h_q.push_back(new_d);
                    d2h_first = 0;
                end
                if (ll_incom_start) d2h_first = 1;
                if (ll_incom_done) begin
                    stat_wait = 1;                       // status one cycle after done
                    stat_err = 0;
                end
                if (ll_incom_invalidate) begin
                    stat_wait = 2;                       // invalidate is delayed once more
                    stat_err = 1;
                end
            end
        end
        // H2D host writer holds a dword until it is taken
        if (!h2d_valid || acc) begin
            if (h2d_left == 0 && h2d_fis_left != 0) begin
                h2d_left = len_min + xorshift() % (len_max - len_min + 1);
                h2d_fis_left--;
                h2d_first = 1;
            end
            if (h2d_left != 0 && xorshift() % 4 != 0) begin
                h2d_valid <= 1'b1;
                h2d_data  <= dword_t'(xorshift());
                h2d_mask  <= mask_t'(xorshift());
                h2d_type  <= h2d_first ? FIS_HEAD : (h2d_left == 1 ? FIS_LAST : FIS_DATA);
                h2d_first = 0;
                h2d_left--;
            end else begin
                h2d_valid <= 1'b0;
            end
        end
        ll_strobe <= (xorshift() % 100) < strobe_pct;
        d2h_ready <= (xorshift() % 100) < ready_pct;
        // link acks a frame request after a random delay
        ll_frame_ack <= 1'b0;
        if (ack_en && ll_frame_req && !ll_frame_ack) begin
            if (ack_cnt == 0) ack_cnt = 1 + xorshift() % 8;
            else begin
                ack_cnt--;
                if (ack_cnt == 0) ll_frame_ack <= 1'b1;
            end
        end
        // link starts an incoming FIS only while not busy
        ll_d2h_valid <= 1'b0;
        ll_incom_start <= 1'b0;
        ll_incom_done <= 1'b0;
        ll_incom_invalidate <= 1'b0;
        if (d2h_gap != 0) d2h_gap--;
        else if (d2h_phase == 0) begin
            if (d2h_fis_left != 0 && !ll_d2h_busy) begin
                ll_incom_start <= 1'b1;
                d2h_left = 1 + xorshift() % 16;
                d2h_bad = (xorshift() % 4) == 0;
                d2h_fis_left--;
                d2h_phase = 1;
            end
        end else if (d2h_phase == 1) begin
            ll_d2h_valid <= 1'b1;
            ll_d2h_data  <= dword_t'(xorshift());
            ll_d2h_mask  <= mask_t'(xorshift());
            d2h_left--;
            if (d2h_left == 0) d2h_phase = 2;
        end else begin
            if (d2h_bad) ll_incom_invalidate <= 1'b1;
            else ll_incom_done <= 1'b1;
            d2h_phase = 0;
            d2h_gap = 3;                                 // room for the status push
        end
    endtask

    function automatic logic gens_idle();
        return h2d_fis_left == 0 && h2d_left == 0 && !h2d_valid && d2h_fis_left == 0 &&
               d2h_phase == 0 && d2h_gap == 0 && stat_wait == 0;
    endfunction

    task automatic drain();
        strobe_pct = 100;
        ready_pct = 100;
        ack_en = 1;
        while (!gens_idle() || h2d_q.size() != 0 || d2h_q.size() != 0 || ll_frame_req) step();
        repeat (4) step();
    endtask

    task automatic begin_test(string name, int unsigned dwords);
        cur_test = name;
        test_err = errors;
        limit += 4 * dwords;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s: %0d errors", cur_test, errors - test_err);
    endtask

    initial begin
        pcmd_st_cleared = 0;
        h2d_data = '0;
        h2d_mask = '0;
        h2d_type = FIS_DATA;
        h2d_valid = 0;
        ll_strobe = 0;
        ll_frame_ack = 0;
        ll_d2h_data = '0;
        ll_d2h_mask = '0;
        ll_d2h_valid = 0;
        ll_incom_start = 0;
        ll_incom_done = 0;
        ll_incom_invalidate = 0;
        d2h_ready = 0;
        step();
        while (rst) step();
        compare_bit("ready after reset", 1'b1, h2d_ready);

        begin_test("random_traffic", 60 * 31 + 60 * 20);
        h2d_fis_left = 60;
        d2h_fis_left = 60;
        strobe_pct = 60;
        ready_pct = 50;
        while (!gens_idle()) step();
        drain();
        end_test();

        begin_test("long_fis_early_req", 60);
        strobe_pct = 0;
        ack_en = 0;
        len_min = 40;
        len_max = 60;
        lasts_taken = 0;
        h2d_fis_left = 1;
        step();
        while (!ll_frame_req) step();
        compare_bit("req before last", 1'b1, lasts_taken == 0);
        compare_bit("fill at req", 1'b1, h2d_q.size() >= 32);
        drain();
        end_test();

        begin_test("flags_backpressure", 520 + 80 * 20);
        strobe_pct = 0;
        ready_pct = 0;
        len_min = 520;
        len_max = 520;
        h2d_fis_left = 1;
        d2h_fis_left = 80;                               // enough to run into busy
        while (h2d_q.size() < DEPTH - 8 || d2h_q.size() < DEPTH - 64) step();
        repeat (20) step();
        drain();
        end_test();

        begin_test("flush", 2 * 12 + 2 * 20 + 20 * 31 + 20 * 20);
        strobe_pct = 0;
        ready_pct = 0;
        len_min = 2;
        len_max = 12;
        h2d_fis_left = 2;
        d2h_fis_left = 2;
        while (!gens_idle() || ll_frame_req) step();
        pcmd_st_cleared <= 1'b1;
        step();
        pcmd_st_cleared <= 1'b0;
        step();
        compare_bit("ll_h2d_valid after flush", 1'b0, ll_h2d_valid);
        compare_bit("d2h_valid after flush", 1'b0, d2h_valid);
        len_max = 31;
        h2d_fis_left = 20;
        d2h_fis_left = 20;
        strobe_pct = 70;
        ready_pct = 70;
        while (!gens_idle()) step();
        drain();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/sata_fifo_pkg.sv
source/sync_fifo.sv
source/h2d_xmit_buffer.sv
source/d2h_recv_buffer.sv
source/sata_transport_top.sv
verification/tb_clock_gen.sv
verification/tb_sata_transport.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_sata_transport --Mdir obj_dir -o sim_tb &&
    ./obj_dir/sim_tb | tee sim.log &&
    grep -q "^Finished with no errors$" sim.log ||
    { echo "simulation failed"; exit 1; }

echo "simulation passed"
